//--- Makefile
SIM := obj_dir/Vtb_fsq
SRCS := $(shell cat compile.f)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_fsq -f compile.f

clean:
	rm -rf obj_dir

//--- compile.f
rtl/fsq_pkg.sv
rtl/fsq_ram.sv
rtl/fsq_ptr_ctrl.sv
rtl/fetch_issue.sv
rtl/commit_tracker.sv
rtl/fsq_top.sv
tests/fsq_properties.sv
tests/tb_fsq.sv

//--- rtl/commit_tracker.sv
`timescale 1ns/100ps

module commit_tracker import fsq_pkg::*; #(
    parameter int depth = 8,
    localparam int idx_w = $clog2(depth),
    localparam int acc_w = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [commit_w-1:0] commit_num,
    input  logic                enq_we,
    input  logic [idx_w-1:0]    tail,
    input  logic                redirect_en,
    input  logic [idx_w-1:0]    redirect_idx,
    input  logic [idx_w-1:0]    commit_head,
    input  fetch_stream_t       head_stream,
    input  wb_info_t            head_wb,
    output logic                retire,
    output logic                update_valid,
    output logic [vaddr_w-1:0]  update_start_addr,
    output logic [vaddr_w-1:0]  update_target,
    output logic                update_taken,
    output logic                update_mispred
);
    logic [depth-1:0]    mispred;
    logic [acc_w-1:0]    acc;
    logic [acc_w-1:0]    consumed;
    logic                flagged;
    logic [offset_w-1:0] end_off;
    logic [vaddr_w-1:0]  fall_through;
    logic                pred_taken;

    assign flagged = mispred[commit_head];
    // a mispredicted stream ends at the resolved offset
    assign end_off = flagged ? head_wb.offset : head_stream.size;
    assign retire = acc > acc_w'(end_off);
    assign consumed = retire ? acc_w'(end_off) + acc_w'(1) : '0;

    assign fall_through = head_stream.start_addr
                        + ((vaddr_w'(head_stream.size) + vaddr_w'(1)) << 2);
    assign pred_taken = head_stream.target != fall_through;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispred <= '0;
            acc <= '0;
            update_valid <= 1'b0;
        end else begin
            if (enq_we) begin
                mispred[tail] <= 1'b0;
            end
            if (redirect_en) begin
                mispred[redirect_idx] <= 1'b1;
            end
            acc <= acc + acc_w'(commit_num) - consumed;
            update_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            update_start_addr <= head_stream.start_addr;
            update_target <= flagged ? head_wb.target : head_stream.target;
            update_taken <= flagged ? head_wb.taken : pred_taken;
            update_mispred <= flagged;
        end
    end

endmodule

//--- rtl/fetch_issue.sv
`timescale 1ns/100ps

module fetch_issue import fsq_pkg::*; #(
    parameter int depth = 8,
    parameter int cache_credits = 2,
    localparam int idx_w = $clog2(depth),
    localparam int credit_w = $clog2(cache_credits + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             search_avail,
    input  logic             redirect_en,
    input  logic             cache_credit,
    input  logic [idx_w-1:0] search_head,
    input  fetch_stream_t    search_stream,
    output logic             issue_fire,
    output logic             fetch_valid,
    output logic [idx_w-1:0] fetch_idx,
    output fetch_stream_t    fetch_stream
);
    logic [credit_w-1:0] credits;

    assign issue_fire = search_avail & (credits != '0) & ~redirect_en;

    // flushed requests still hand their credit back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= credit_w'(cache_credits);
            fetch_valid <= 1'b0;
        end else begin
            credits <= credits + credit_w'(cache_credit) - credit_w'(issue_fire);
            fetch_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            fetch_idx <= search_head;
        end
    end

    // read port already registered at the issuing edge
    assign fetch_stream = search_stream;

endmodule

//--- rtl/fsq_pkg.sv
package fsq_pkg;

    // virtual address width
    localparam int vaddr_w = 32;

    // offset of an instruction inside a 16-instruction block
    localparam int offset_w = 4;

    // retired instructions per cycle, 0 to 4
    localparam int commit_w = 3;

    // one fetch stream as produced by the predictor
    typedef struct packed {
        logic [vaddr_w-1:0]  start_addr;
        // offset of the last instruction
        logic [offset_w-1:0] size;
        logic [vaddr_w-1:0]  target;
    } fetch_stream_t;

    // outcome resolved by the backend
    typedef struct packed {
        logic                taken;
        logic [offset_w-1:0] offset;
        logic [vaddr_w-1:0]  target;
    } wb_info_t;

endpackage

//--- rtl/fsq_ptr_ctrl.sv
`timescale 1ns/100ps

module fsq_ptr_ctrl #(
    parameter int depth = 8,
    localparam int idx_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             pred_en,
    input  logic             redirect_en,
    input  logic [idx_w-1:0] redirect_idx,
    input  logic             issue_fire,
    input  logic             retire,
    output logic [idx_w-1:0] tail,
    output logic [idx_w-1:0] search_head,
    output logic [idx_w-1:0] commit_head,
    output logic [idx_w-1:0] commit_head_next,
    output logic             search_avail,
    output logic             full,
    output logic             enq_we
);
    logic             tdir;
    logic             sdir;
    logic             cdir;
    logic [depth-1:0] dir_table;
    logic [idx_w-1:0] redirect_n1;
    logic             redirect_dir;

    assign redirect_n1 = redirect_idx + 1'b1;
    // stepping past the last slot starts the next lap
    assign redirect_dir = dir_table[redirect_idx] ^ (&redirect_idx);

    assign full = (tail == commit_head) && (tdir != cdir);
    assign search_avail = (search_head != tail) || (sdir != tdir);
    // younger streams die on a redirect, so no enqueue then
    assign enq_we = pred_en & ~full & ~redirect_en;
    assign commit_head_next = retire ? commit_head + 1'b1 : commit_head;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
            tdir <= 1'b0;
            search_head <= '0;
            sdir <= 1'b0;
            commit_head <= '0;
            cdir <= 1'b0;
            dir_table <= '0;
        end else begin
            if (redirect_en) begin
                tail <= redirect_n1;
                tdir <= redirect_dir;
            end else if (enq_we) begin
                tail <= tail + 1'b1;
                tdir <= tdir ^ (&tail);
            end

            // redirect beats a same-cycle issue
            if (redirect_en) begin
                search_head <= redirect_n1;
                sdir <= redirect_dir;
            end else if (issue_fire) begin
                search_head <= search_head + 1'b1;
                sdir <= sdir ^ (&search_head);
            end

            if (retire) begin
                commit_head <= commit_head_next;
                cdir <= cdir ^ (&commit_head);
            end

            if (enq_we) begin
                dir_table[tail] <= tdir;
            end
        end
    end

endmodule

//--- rtl/fsq_ram.sv
`timescale 1ns/100ps

module fsq_ram #(
    parameter int depth = 8,
    parameter int rd_ports = 1,
    parameter type entry_t = logic,
    localparam int idx_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  logic [idx_w-1:0] waddr,
    input  entry_t           wdata,
    input  logic [idx_w-1:0] raddr [rd_ports],
    output entry_t           rdata [rd_ports]
);
    entry_t mem [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '0};
            rdata <= '{default: '0};
        end else begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            // write-first, a read of the entry being written sees new data
            for (int i = 0; i < rd_ports; i++) begin
                rdata[i] <= (we && waddr == raddr[i]) ? wdata : mem[raddr[i]];
            end
        end
    end

endmodule

//--- rtl/fsq_top.sv
`timescale 1ns/100ps

module fsq_top import fsq_pkg::*; #(
    parameter int depth = 8,
    parameter int cache_credits = 2,
    localparam int idx_w = $clog2(depth)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                pred_en,
    input  fetch_stream_t       pred_stream,
    output logic [idx_w-1:0]    pred_idx,
    output logic                pred_stall,
    input  logic                cache_credit,
    output logic                fetch_valid,
    output logic [idx_w-1:0]    fetch_idx,
    output fetch_stream_t       fetch_stream,
    output logic                cache_flush,
    input  logic                redirect_en,
    input  logic [idx_w-1:0]    redirect_idx,
    input  logic [offset_w-1:0] redirect_offset,
    input  logic                redirect_taken,
    input  logic [vaddr_w-1:0]  redirect_target,
    input  logic [commit_w-1:0] commit_num,
    output logic                squash,
    output logic [vaddr_w-1:0]  squash_target,
    output logic                update_valid,
    output logic [vaddr_w-1:0]  update_start_addr,
    output logic [vaddr_w-1:0]  update_target,
    output logic                update_taken,
    output logic                update_mispred
);
    logic [idx_w-1:0] tail;
    logic [idx_w-1:0] search_head;
    logic [idx_w-1:0] commit_head;
    logic [idx_w-1:0] commit_head_next;
    logic             search_avail;
    logic             full;
    logic             enq_we;
    logic             issue_fire;
    logic             retire;
    logic [idx_w-1:0] stream_raddr [2];
    fetch_stream_t    stream_rdata [2];
    logic [idx_w-1:0] wb_raddr [1];
    wb_info_t         wb_rdata [1];
    wb_info_t         wb_wdata;

    assign pred_idx = tail;
    assign pred_stall = full;
    assign cache_flush = redirect_en;

    // port 0 feeds the cache, port 1 the commit head
    assign stream_raddr[0] = search_head;
    assign stream_raddr[1] = commit_head_next;
    assign wb_raddr[0] = commit_head_next;
    assign wb_wdata = '{taken: redirect_taken, offset: redirect_offset, target: redirect_target};

    fsq_ptr_ctrl #(.depth(depth)) ptr_ctrl_i (
        .clk(clk), .rst(rst), .pred_en(pred_en),
        .redirect_en(redirect_en), .redirect_idx(redirect_idx),
        .issue_fire(issue_fire), .retire(retire),
        .tail(tail), .search_head(search_head), .commit_head(commit_head),
        .commit_head_next(commit_head_next), .search_avail(search_avail),
        .full(full), .enq_we(enq_we)
    );

    fsq_ram #(.depth(depth), .rd_ports(2), .entry_t(fetch_stream_t)) stream_ram (
        .clk(clk), .rst(rst), .we(enq_we), .waddr(tail), .wdata(pred_stream),
        .raddr(stream_raddr), .rdata(stream_rdata)
    );

    fsq_ram #(.depth(depth), .rd_ports(1), .entry_t(wb_info_t)) wb_ram (
        .clk(clk), .rst(rst), .we(redirect_en), .waddr(redirect_idx), .wdata(wb_wdata),
        .raddr(wb_raddr), .rdata(wb_rdata)
    );

    fetch_issue #(.depth(depth), .cache_credits(cache_credits)) fetch_issue_i (
        .clk(clk), .rst(rst), .search_avail(search_avail), .redirect_en(redirect_en),
        .cache_credit(cache_credit), .search_head(search_head),
        .search_stream(stream_rdata[0]), .issue_fire(issue_fire),
        .fetch_valid(fetch_valid), .fetch_idx(fetch_idx), .fetch_stream(fetch_stream)
    );

    commit_tracker #(.depth(depth)) commit_tracker_i (
        .clk(clk), .rst(rst), .commit_num(commit_num), .enq_we(enq_we), .tail(tail),
        .redirect_en(redirect_en), .redirect_idx(redirect_idx),
        .commit_head(commit_head), .head_stream(stream_rdata[1]), .head_wb(wb_rdata[0]),
        .retire(retire), .update_valid(update_valid),
        .update_start_addr(update_start_addr), .update_target(update_target),
        .update_taken(update_taken), .update_mispred(update_mispred)
    );

    // squash goes back to the predictor a cycle after the redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squash <= 1'b0;
        end else begin
            squash <= redirect_en;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_en) begin
            squash_target <= redirect_target;
        end
    end

endmodule

//--- tests/fsq_properties.sv
`timescale 1ns/100ps

module fsq_properties import fsq_pkg::*; #(
    parameter int depth = 8,
    parameter int cache_credits = 2,
    localparam int idx_w = $clog2(depth)
) (
    input logic               clk,
    input logic               rst,
    input logic               pred_stall,
    input logic [idx_w-1:0]   pred_idx,
    input logic               cache_credit,
    input logic               fetch_valid,
    input logic               redirect_en,
    input logic [idx_w-1:0]   redirect_idx,
    input logic [vaddr_w-1:0] redirect_target,
    input logic               squash,
    input logic [vaddr_w-1:0] squash_target,
    input logic               update_valid
);
    int outstanding;

    // requests seen by the cache and not yet credited back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(fetch_valid) - int'(cache_credit);
        end
    end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !fetch_valid && !squash && !update_valid && !pred_stall)
        else $error("fetch, squash, update or stall active during reset");

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= cache_credits)
        else $error("more cache requests in flight than credits");

    squash_follows: assert property (@(posedge clk) disable iff (rst)
        redirect_en |=> squash && squash_target == $past(redirect_target))
        else $error("no squash with the redirect target after a redirect");

    squash_source: assert property (@(posedge clk) disable iff (rst)
        squash |-> $past(redirect_en))
        else $error("squash without a redirect");

    redirect_tail: assert property (@(posedge clk) disable iff (rst)
        redirect_en |=> pred_idx == $past(redirect_idx) + 1'b1)
        else $error("tail not one past the redirected stream");

    // redirect wins over an issue in the same cycle
    redirect_no_fetch: assert property (@(posedge clk) disable iff (rst)
        redirect_en |=> !fetch_valid)
        else $error("fetch request issued in a redirect cycle");

endmodule

//--- tests/tb_fsq.sv
`timescale 1ns/100ps

module tb_fsq import fsq_pkg::*; ();
    localparam int depth = 8;
    localparam int cache_credits = 2;
    localparam int idx_w = $clog2(depth);
    localparam int redir_k = 4;

    typedef struct packed {
        logic [vaddr_w-1:0] addr;
        logic [vaddr_w-1:0] target;
        logic               taken;
        logic               mispred;
    } upd_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                pred_en;
    fetch_stream_t       pred_stream;
    logic [idx_w-1:0]    pred_idx;
    logic                pred_stall;
    logic                cache_credit = 1'b0;
    logic                fetch_valid;
    logic [idx_w-1:0]    fetch_idx;
    fetch_stream_t       fetch_stream;
    logic                cache_flush;
    logic                redirect_en;
    logic [idx_w-1:0]    redirect_idx;
    logic [offset_w-1:0] redirect_offset;
    logic                redirect_taken;
    logic [vaddr_w-1:0]  redirect_target;
    logic [commit_w-1:0] commit_num;
    logic                squash;
    logic [vaddr_w-1:0]  squash_target;
    logic                update_valid;
    logic [vaddr_w-1:0]  update_start_addr;
    logic [vaddr_w-1:0]  update_target;
    logic                update_taken;
    logic                update_mispred;

    logic [31:0]         rng;
    logic [idx_w-1:0]    tail_m;
    int                  errors;
    int                  checks;
    int                  fetches;
    int                  updates;
    int                  cycle;
    int                  credit_due [$];
    logic [idx_w-1:0]    exp_idx [$];
    fetch_stream_t       exp_fetch [$];
    upd_t                exp_upd [$];
    fetch_stream_t       model [depth];

    fsq_top #(.depth(depth), .cache_credits(cache_credits)) dut_i (.*);

    bind fsq_top fsq_properties #(.depth(depth), .cache_credits(cache_credits)) props_i (
        .clk(clk), .rst(rst), .pred_stall(pred_stall), .pred_idx(pred_idx),
        .cache_credit(cache_credit), .fetch_valid(fetch_valid),
        .redirect_en(redirect_en), .redirect_idx(redirect_idx),
        .redirect_target(redirect_target), .squash(squash),
        .squash_target(squash_target), .update_valid(update_valid)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic wait_count(input bit of_updates, input int target, input string what);
        int n;
        n = 0;
        while ((of_updates ? updates : fetches) < target && n < 500) begin
            @(negedge clk);
            n++;
        end
        if ((of_updates ? updates : fetches) < target) begin
            $display("timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic offer_stream(output bit accepted);
        fetch_stream_t s;
        rng = xorshift(rng);
        s.start_addr = {rng[31:2], 2'b00};
        rng = xorshift(rng);
        s.target = {rng[31:2], 2'b00};
        s.size = rng[offset_w-1:0];
        pred_stream = s;
        pred_en = 1'b1;
        accepted = !pred_stall;
        if (accepted) begin
            compare_value("pred_idx", 32'(pred_idx), 32'(tail_m));
            model[tail_m] = s;
            exp_fetch.push_back(s);
            exp_idx.push_back(tail_m);
            tail_m++;
        end
        @(negedge clk);
        pred_en = 1'b0;
    endtask

    // cache model and response monitors
    always @(negedge clk) begin
        fetch_stream_t e;
        upd_t          u;
        cycle++;
        cache_credit = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            cache_credit = 1'b1;
        end
        if (!rst && fetch_valid) begin
            if (exp_fetch.size() == 0) begin
                $display("fetch request for index %0d that was never accepted", fetch_idx);
                errors++;
            end else begin
                e = exp_fetch.pop_front();
                compare_value("fetch_idx", 32'(fetch_idx), 32'(exp_idx.pop_front()));
                compare_value("fetch_stream.start_addr", fetch_stream.start_addr, e.start_addr);
                compare_value("fetch_stream.size", 32'(fetch_stream.size), 32'(e.size));
                compare_value("fetch_stream.target", fetch_stream.target, e.target);
            end
            // flushed or not, every request hands its credit back
            credit_due.push_back(cycle + 1 + int'(fetch_stream.start_addr[5:4]));
            fetches++;
        end
        if (!rst && update_valid) begin
            if (exp_upd.size() == 0) begin
                $display("predictor update with no stream left to retire");
                errors++;
            end else begin
                u = exp_upd.pop_front();
                compare_value("update_start_addr", update_start_addr, u.addr);
                compare_value("update_target", update_target, u.target);
                compare_value("update_mispred", 32'(update_mispred), 32'(u.mispred));
                compare_value("update_taken", 32'(update_taken), 32'(u.taken));
            end
            updates++;
        end
    end

    initial begin
        bit                 accepted;
        int                 total;
        int                 n;
        upd_t               u;
        logic [vaddr_w-1:0] seq_addr;
        rst = 1'b1;
        pred_en = 1'b0;
        pred_stream = '0;
        redirect_en = 1'b0;
        redirect_idx = '0;
        redirect_offset = '0;
        redirect_taken = 1'b0;
        redirect_target = '0;
        commit_num = '0;
        rng = 32'd42;
        tail_m = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // fill the queue, the last offer meets a full queue
        for (int i = 0; i <= depth; i++) begin
            offer_stream(accepted);
            compare_value("pred_stall", 32'(!accepted), 32'(i == depth));
        end
        wait_count(1'b0, depth, "the queued fetch requests");
        repeat (10) @(negedge clk);

        rng = xorshift(rng);
        redirect_idx = idx_w'(redir_k);
        redirect_offset = rng[offset_w-1:0];
        redirect_taken = 1'b1;
        redirect_target = {rng[31:2], 2'b00};
        redirect_en = 1'b1;
        @(posedge clk);
        compare_value("cache_flush", 32'(cache_flush), 32'd1);
        @(negedge clk);
        redirect_en = 1'b0;
        compare_value("squash", 32'(squash), 32'd1);
        compare_value("squash_target", squash_target, redirect_target);
        compare_value("pred_idx", 32'(pred_idx), 32'((redir_k + 1) % depth));
        @(negedge clk);
        compare_value("squash", 32'(squash), 32'd0);
        compare_value("cache_flush", 32'(cache_flush), 32'd0);
        tail_m = idx_w'((redir_k + 1) % depth);

        // redirect again while this stream waits for its fetch, so it dies unfetched
        offer_stream(accepted);
        void'(exp_fetch.pop_back());
        void'(exp_idx.pop_back());
        redirect_en = 1'b1;
        @(negedge clk);
        redirect_en = 1'b0;
        tail_m = idx_w'((redir_k + 1) % depth);

        offer_stream(accepted);
        offer_stream(accepted);
        wait_count(1'b0, depth + 2, "fetch requests after the redirect");

        // streams 0 to k+2 survive, k ends at the resolved offset
        total = 0;
        for (int i = 0; i < redir_k + 3; i++) begin
            u.addr = model[i].start_addr;
            u.mispred = (i == redir_k);
            u.target = u.mispred ? redirect_target : model[i].target;
            // taken when the target is not the next sequential block
            seq_addr = model[i].start_addr + 32'(4 * (int'(model[i].size) + 1));
            u.taken = u.mispred ? redirect_taken : (model[i].target != seq_addr);
            exp_upd.push_back(u);
            total += u.mispred ? int'(redirect_offset) + 1 : int'(model[i].size) + 1;
        end
        while (total > 0) begin
            rng = xorshift(rng);
            n = int'(rng[2:0]) % 5;
            if (n > total) begin
                n = total;
            end
            commit_num = commit_w'(n);
            total -= n;
            @(negedge clk);
        end
        commit_num = '0;
        wait_count(1'b1, redir_k + 3, "predictor updates");
        repeat (10) @(negedge clk);
        finish_run();
    end

endmodule
